/* kyber_scalar_mul.f */
rtl/kyber_pkg.sv
rtl/coeff_ram.sv
rtl/coeff_counter.sv
rtl/scale_ctrl.sv
rtl/coeff_mult.sv
rtl/montgomery_reduce.sv
rtl/kyber_scalar_mul.sv
tb/tb_kyber_scalar_mul.sv

/* rtl/coeff_counter.sv */
`timescale 1ns/1ps

module coeff_counter #(
  parameter int ADDR_W = 8
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              clear,
  input  logic              rd_adv,
  input  logic              wr_adv,
  output logic [ADDR_W-1:0] rd_addr,
  output logic              rd_last,
  output logic [ADDR_W-1:0] wr_addr,
  output logic              wr_last
);

  //////////////////////////////////////////////////
  // read side, one step per issued read
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_addr <= '0;
    end else if (clear) begin
      // new pass starts at coeff 0
      rd_addr <= '0;
    end else if (rd_adv) begin
      rd_addr <= rd_addr + 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // write side, one step per reduced result
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_addr <= '0;
    end else if (clear) begin
      wr_addr <= '0;
    end else if (wr_adv) begin
      wr_addr <= wr_addr + 1'b1;
    end
  end

  // final address reached
  assign rd_last = (rd_addr == {ADDR_W{1'b1}});
  assign wr_last = (wr_addr == {ADDR_W{1'b1}});

endmodule

/* rtl/coeff_mult.sv */
`timescale 1ns/1ps

module coeff_mult (
  input  logic               clk,
  input  logic               rst_n,
  input  logic signed [15:0] coeff,
  input  logic               in_valid,
  input  kyber_pkg::op_e     op,
  input  logic signed [15:0] scalar,
  output logic signed [31:0] prod,
  output logic               prod_valid
);

  // second operand picked by opcode
  logic signed [15:0] operand;

  always_comb begin
    case (op)
      kyber_pkg::OP_FQMUL:  operand = scalar;
      // plain reduce: multiply by one
      default:              operand = 16'sd1;
    endcase
  end

  // signed product register
  always_ff @(posedge clk) begin
    prod <= coeff * operand;
  end

  // valid follows the product
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      prod_valid <= 1'b0;
    end else begin
      prod_valid <= in_valid;
    end
  end

endmodule

/* rtl/coeff_ram.sv */
`timescale 1ns/1ps

module coeff_ram #(
  parameter int ADDR_W = 8
) (
  input  logic                      clk,
  input  kyber_pkg::coeff_wr_t      host_wr,
  input  kyber_pkg::coeff_wr_t      eng_wr,
  input  logic                      rd_en,
  input  logic [ADDR_W-1:0]         rd_addr,
  output logic signed [15:0]        eng_rdata,
  output logic                      rd_valid,
  input  logic [ADDR_W-1:0]         host_raddr,
  output logic signed [15:0]        host_rdata
);

  // coefficient storage, one word per coeff
  logic signed [15:0] mem [0:(2**ADDR_W)-1];

  // single write port, engine has priority
  always_ff @(posedge clk) begin
    if (eng_wr.en) begin
      mem[eng_wr.addr] <= eng_wr.data;
    end else if (host_wr.en) begin
      mem[host_wr.addr] <= host_wr.data;
    end
  end

  // engine read, data one cycle after rd_en
  always_ff @(posedge clk) begin
    if (rd_en) begin
      eng_rdata <= mem[rd_addr];
    end
    // qualifier rides alongside the data
    rd_valid <= rd_en;
  end

  // host read, always enabled
  always_ff @(posedge clk) begin
    host_rdata <= mem[host_raddr];
  end

endmodule

/* rtl/kyber_pkg.sv */
package kyber_pkg;

  //////////////////////////////////////////////////
  // kyber arithmetic constants
  //////////////////////////////////////////////////

  // prime modulus
  localparam int KYBER_Q = 3329;
  // q^-1 mod 2^16 in unsigned form
  localparam int QINV = 62209;
  // coefficients per polynomial
  localparam int N_COEFFS = 256;
  // montgomery pipeline depth in cycles
  localparam int REDUCE_LAT = 4;

  //////////////////////////////////////////////////
  // enums
  //////////////////////////////////////////////////

  // pass opcode
  typedef enum logic {
    // coeff * scalar before the reduce
    OP_FQMUL  = 1'b0,
    // coeff * 1 before the reduce
    OP_REDUCE = 1'b1
  } op_e;

  // pass sequencer states
  typedef enum logic [1:0] {
    ST_IDLE  = 2'd0,
    ST_ISSUE = 2'd1,
    ST_DRAIN = 2'd2,
    ST_DONE  = 2'd3
  } ctrl_state_e;

  //////////////////////////////////////////////////
  // buffer write request
  //////////////////////////////////////////////////

  typedef struct packed {
    logic                          en;
    logic [$clog2(N_COEFFS)-1:0]   addr;
    logic signed [15:0]            data;
  } coeff_wr_t;

endpackage

/* rtl/kyber_scalar_mul.sv */
`timescale 1ns/1ps

module kyber_scalar_mul #(
  parameter int ADDR_W = $clog2(kyber_pkg::N_COEFFS)
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 start,
  input  kyber_pkg::op_e       op,
  input  logic signed [15:0]   scalar,
  input  kyber_pkg::coeff_wr_t host_wr,
  input  logic [ADDR_W-1:0]    host_raddr,
  output logic signed [15:0]   host_rdata,
  output logic                 busy,
  output logic                 done
);

  // control
  logic                 clear;
  logic                 rd_en;
  logic                 rd_last;
  logic                 wr_last;
  logic [ADDR_W-1:0]    rd_addr;
  logic [ADDR_W-1:0]    wr_addr;
  kyber_pkg::op_e       op_q;
  logic signed [15:0]   scalar_q;

  // datapath
  logic signed [15:0]   eng_rdata;
  logic                 rd_valid;
  logic signed [31:0]   prod;
  logic                 prod_valid;
  logic signed [15:0]   res;
  logic                 res_valid;
  kyber_pkg::coeff_wr_t eng_wr;

  //////////////////////////////////////////////////
  // in-place write-back
  //////////////////////////////////////////////////

  assign eng_wr.en   = res_valid;
  assign eng_wr.addr = wr_addr;
  assign eng_wr.data = res;

  coeff_ram #(.ADDR_W(ADDR_W)) ram_i (
    .clk        (clk),
    .host_wr    (host_wr),
    .eng_wr     (eng_wr),
    .rd_en      (rd_en),
    .rd_addr    (rd_addr),
    .eng_rdata  (eng_rdata),
    .rd_valid   (rd_valid),
    .host_raddr (host_raddr),
    .host_rdata (host_rdata)
  );

  // one read per issue cycle, one write per result
  coeff_counter #(.ADDR_W(ADDR_W)) cnt_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .clear   (clear),
    .rd_adv  (rd_en),
    .wr_adv  (res_valid),
    .rd_addr (rd_addr),
    .rd_last (rd_last),
    .wr_addr (wr_addr),
    .wr_last (wr_last)
  );

  scale_ctrl ctrl_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .start     (start),
    .op        (op),
    .scalar    (scalar),
    .rd_last   (rd_last),
    .wr_last   (wr_last),
    .res_valid (res_valid),
    .clear     (clear),
    .rd_en     (rd_en),
    .op_q      (op_q),
    .scalar_q  (scalar_q),
    .busy      (busy),
    .done      (done)
  );

  coeff_mult mult_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .coeff      (eng_rdata),
    .in_valid   (rd_valid),
    .op         (op_q),
    .scalar     (scalar_q),
    .prod       (prod),
    .prod_valid (prod_valid)
  );

  montgomery_reduce red_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .a         (prod),
    .in_valid  (prod_valid),
    .res       (res),
    .res_valid (res_valid)
  );

endmodule

/* rtl/montgomery_reduce.sv */
`timescale 1ns/1ps

module montgomery_reduce (
  input  logic               clk,
  input  logic               rst_n,
  input  logic signed [31:0] a,
  input  logic               in_valid,
  output logic signed [15:0] res,
  output logic               res_valid
);

  localparam logic signed [31:0] QINV_S = kyber_pkg::QINV;
  localparam logic signed [31:0] Q_S    = kyber_pkg::KYBER_Q;

  // stage regs
  logic signed [31:0] a_q;
  logic signed [15:0] u;
  logic signed [31:0] t;
  // a delayed to line up with t
  logic signed [31:0] a_d2;
  logic signed [31:0] a_d3;

  logic signed [31:0] a_qinv;
  logic signed [31:0] diff;

  logic [kyber_pkg::REDUCE_LAT-1:0] vld_sr;

  // only the low half of a*qinv matters
  assign a_qinv = a_q * QINV_S;
  // low 16 bits cancel, so the top half is the result
  assign diff   = a_d3 - t;

  //////////////////////////////////////////////////
  // datapath stages
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    // s1: capture
    a_q  <= a;
    // s2: u = low16(a*qinv), signed
    u    <= a_qinv[15:0];
    a_d2 <= a_q;
    // s3: t = u*q
    t    <= u * Q_S;
    a_d3 <= a_d2;
    // s4: (a - t) >>> 16
    res  <= diff[31:16];
  end

  // one bit per stage
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      vld_sr <= '0;
    end else begin
      vld_sr <= {vld_sr[kyber_pkg::REDUCE_LAT-2:0], in_valid};
    end
  end

  assign res_valid = vld_sr[kyber_pkg::REDUCE_LAT-1];

endmodule

/* rtl/scale_ctrl.sv */
`timescale 1ns/1ps

module scale_ctrl (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               start,
  input  kyber_pkg::op_e     op,
  input  logic signed [15:0] scalar,
  input  logic               rd_last,
  input  logic               wr_last,
  input  logic               res_valid,
  output logic               clear,
  output logic               rd_en,
  output kyber_pkg::op_e     op_q,
  output logic signed [15:0] scalar_q,
  output logic               busy,
  output logic               done
);

  kyber_pkg::ctrl_state_e state_q;
  kyber_pkg::ctrl_state_e state_d;

  // start only counts when idle
  logic accept;

  assign accept = (state_q == kyber_pkg::ST_IDLE) && start;

  //////////////////////////////////////////////////
  // next state
  //////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      kyber_pkg::ST_IDLE: begin
        if (start) begin
          state_d = kyber_pkg::ST_ISSUE;
        end
      end
      kyber_pkg::ST_ISSUE: begin
        // last read goes out this cycle
        if (rd_last) begin
          state_d = kyber_pkg::ST_DRAIN;
        end
      end
      kyber_pkg::ST_DRAIN: begin
        // wait for final write-back
        if (res_valid && wr_last) begin
          state_d = kyber_pkg::ST_DONE;
        end
      end
      default: begin
        state_d = kyber_pkg::ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= kyber_pkg::ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // opcode and scalar held for the whole pass
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      op_q     <= kyber_pkg::OP_FQMUL;
      scalar_q <= '0;
    end else if (accept) begin
      op_q     <= op;
      scalar_q <= scalar;
    end
  end

  //////////////////////////////////////////////////
  // outputs
  //////////////////////////////////////////////////

  // counters reset on the same edge we enter issue
  assign clear = accept;
  assign rd_en = (state_q == kyber_pkg::ST_ISSUE);
  assign busy  = (state_q == kyber_pkg::ST_ISSUE) || (state_q == kyber_pkg::ST_DRAIN);
  assign done  = (state_q == kyber_pkg::ST_DONE);

endmodule

/* tb/tb_kyber_scalar_mul.sv */
`timescale 1ns/1ps

module tb_kyber_scalar_mul;

  localparam int N          = kyber_pkg::N_COEFFS;
  localparam int Q          = kyber_pkg::KYBER_Q;
  localparam int CLK_PERIOD = 8;
  // accept + one read per coeff + ram and multiply + reduce depth
  localparam int DONE_BOUND = 1 + N + 2 + kyber_pkg::REDUCE_LAT;
  // total passes over all tests with load and readback
  localparam int N_PASSES   = 8;
  localparam int WATCHDOG_CYCLES = N_PASSES * (300 + 2 * N);

  logic                 clk;
  logic                 rst_n;
  logic                 start;
  kyber_pkg::op_e       op;
  logic signed [15:0]   scalar;
  kyber_pkg::coeff_wr_t host_wr;
  logic [7:0]           host_raddr;
  logic signed [15:0]   host_rdata;
  logic                 busy;
  logic                 done;

  // buffer contents before a pass and after it
  logic signed [15:0] init_vals [0:N-1];
  logic signed [15:0] exp_vals  [0:N-1];

  logic [31:0] rng_state;
  int          err_count;
  int          tests_run;
  int          tests_failed;

  kyber_scalar_mul #(.ADDR_W(8)) dut_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .start      (start),
    .op         (op),
    .scalar     (scalar),
    .host_wr    (host_wr),
    .host_raddr (host_raddr),
    .host_rdata (host_rdata),
    .busy       (busy),
    .done       (done)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  //////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  // low half of the next xorshift word
  function automatic logic signed [15:0] rand16();
    logic [31:0] r;
    r = xorshift32();
    return r[15:0];
  endfunction

  // montgomery rule on a wide signed product
  function automatic int mont_ref(input longint a);
    longint             prod;
    logic signed [15:0] u;
    longint             t;
    prod = a * kyber_pkg::QINV;
    u    = prod[15:0];
    t    = u * Q;
    return int'((a - t) >>> 16);
  endfunction

  function automatic logic signed [15:0] expect_scaled(input logic signed [15:0] c,
                                                       input kyber_pkg::op_e p_op,
                                                       input logic signed [15:0] s);
    longint b;
    // reduce multiplies by one
    b = (p_op == kyber_pkg::OP_FQMUL) ? longint'(s) : 1;
    return mont_ref(longint'(c) * b);
  endfunction

  task automatic set_expected(input kyber_pkg::op_e p_op, input logic signed [15:0] s);
    for (int i = 0; i < N; i++) begin
      exp_vals[i] = expect_scaled(init_vals[i], p_op, s);
    end
  endtask

  //////////////////////////////////////////////////
  // host side helpers
  //////////////////////////////////////////////////

  task automatic load_buffer();
    for (int i = 0; i < N; i++) begin
      @(negedge clk);
      host_wr.en   = 1'b1;
      host_wr.addr = i[7:0];
      host_wr.data = init_vals[i];
    end
    @(negedge clk);
    host_wr.en = 1'b0;
  endtask

  // pulse start and watch busy each cycle until done
  // a nonzero poke_cycle adds a stray start mid-pass
  task automatic run_pass(input kyber_pkg::op_e p_op, input logic signed [15:0] s,
                          input int poke_cycle);
    int cycles;
    bit seen;
    cycles = 0;
    seen   = 1'b0;
    @(negedge clk);
    start  = 1'b1;
    op     = p_op;
    scalar = s;
    while (!seen && cycles < DONE_BOUND) begin
      @(negedge clk);
      cycles++;
      start = (cycles == poke_cycle);
      // a stray start carries the other opcode
      if (cycles == poke_cycle) begin
        op = (p_op == kyber_pkg::OP_FQMUL) ? kyber_pkg::OP_REDUCE : kyber_pkg::OP_FQMUL;
      end
      if (done) begin
        seen = 1'b1;
        if (busy) begin
          $display("Error at %0t: busy still high with done", $time);
          err_count++;
        end
      end else if (!busy) begin
        $display("Error at %0t: busy low at cycle %0d before done", $time, cycles);
        err_count++;
      end
    end
    start = 1'b0;
    if (!seen) begin
      $display("done did not arrive within %0d cycles of start", DONE_BOUND);
      err_count++;
    end
  endtask

  // no late done and no restarted pass
  task automatic expect_quiet(input int n);
    repeat (n) begin
      @(negedge clk);
      if (done || busy) begin
        $display("Error at %0t: done=%0b busy=%0b after pass ended", $time, done, busy);
        err_count++;
      end
    end
  endtask

  // readback data lands one cycle after its address
  // range only holds for a reduce of 16-bit inputs
  task automatic check_buffer(input bit check_range);
    for (int i = 0; i <= N; i++) begin
      @(negedge clk);
      if (i > 0) begin
        if (host_rdata !== exp_vals[i-1]) begin
          $display("Error at %0t: coeff %0d expected %0d got %0d",
                   $time, i - 1, exp_vals[i-1], host_rdata);
          err_count++;
        end
        if (check_range && (host_rdata <= -Q || host_rdata >= Q)) begin
          $display("Error at %0t: coeff %0d value %0d outside (-q, q)",
                   $time, i - 1, host_rdata);
          err_count++;
        end
      end
      if (i < N) begin
        host_raddr = i[7:0];
      end
    end
  endtask

  task automatic finish_test(input string name, input int errs_before);
    tests_run++;
    if (err_count > errs_before) begin
      tests_failed++;
      $display("%s: FAILED with %0d errors", name, err_count - errs_before);
    end else begin
      $display("%s: ok", name);
    end
  endtask

  task automatic fill_random();
    for (int i = 0; i < N; i++) begin
      init_vals[i] = rand16();
    end
  endtask

  //////////////////////////////////////////////////
  // directed tests
  //////////////////////////////////////////////////

  task automatic reduce_random();
    int e0;
    e0 = err_count;
    fill_random();
    load_buffer();
    set_expected(kyber_pkg::OP_REDUCE, 16'sd0);
    run_pass(kyber_pkg::OP_REDUCE, 16'sd0, 0);
    check_buffer(1'b1);
    finish_test("reduce_random", e0);
  endtask

  task automatic fqmul_random();
    int                 e0;
    logic signed [15:0] s;
    e0 = err_count;
    fill_random();
    s = rand16();
    load_buffer();
    set_expected(kyber_pkg::OP_FQMUL, s);
    run_pass(kyber_pkg::OP_FQMUL, s, 0);
    check_buffer(1'b0);
    finish_test("fqmul_random", e0);
  endtask

  task automatic edge_operands();
    int                 e0;
    logic signed [15:0] edge_coeffs [0:4];
    logic signed [15:0] edge_scalars [0:2];
    e0 = err_count;
    edge_coeffs  = '{16'sh8000, 16'sh7fff, 16'sd0, 16'sd3329, -16'sd3329};
    edge_scalars = '{16'sd1, -16'sd1, 16'sh7fff};
    for (int k = 0; k < 3; k++) begin
      // edge values mixed with an address pattern
      for (int i = 0; i < N; i++) begin
        if ((i % 8) < 5) begin
          init_vals[i] = edge_coeffs[i % 8];
        end else begin
          init_vals[i] = {i[7:0], ~i[7:0]};
        end
      end
      load_buffer();
      set_expected(kyber_pkg::OP_FQMUL, edge_scalars[k]);
      run_pass(kyber_pkg::OP_FQMUL, edge_scalars[k], 0);
      check_buffer(1'b0);
    end
    finish_test("edge_operands", e0);
  endtask

  task automatic start_while_busy();
    int                 e0;
    logic signed [15:0] s;
    e0 = err_count;
    fill_random();
    s = rand16();
    load_buffer();
    set_expected(kyber_pkg::OP_FQMUL, s);
    // stray start lands mid-issue
    run_pass(kyber_pkg::OP_FQMUL, s, 100);
    expect_quiet(16);
    check_buffer(1'b0);
    finish_test("start_while_busy", e0);
  endtask

  task automatic back_to_back();
    int                 e0;
    logic signed [15:0] s;
    e0 = err_count;
    fill_random();
    s = rand16();
    load_buffer();
    set_expected(kyber_pkg::OP_FQMUL, s);
    // second pass reduces what the first wrote back
    for (int i = 0; i < N; i++) begin
      exp_vals[i] = expect_scaled(exp_vals[i], kyber_pkg::OP_REDUCE, 16'sd0);
    end
    run_pass(kyber_pkg::OP_FQMUL, s, 0);
    run_pass(kyber_pkg::OP_REDUCE, 16'sd0, 0);
    check_buffer(1'b1);
    finish_test("back_to_back", e0);
  endtask

  //////////////////////////////////////////////////
  // main sequence and watchdog
  //////////////////////////////////////////////////

  initial begin
    rng_state    = 32'd3905;
    err_count    = 0;
    tests_run    = 0;
    tests_failed = 0;
    rst_n        = 1'b0;
    start        = 1'b0;
    op           = kyber_pkg::OP_FQMUL;
    scalar       = '0;
    host_wr      = '0;
    host_raddr   = '0;
    repeat (3) @(negedge clk);
    rst_n = 1'b1;
    reduce_random();
    fqmul_random();
    edge_operands();
    start_while_busy();
    back_to_back();
    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, err_count);
    if (err_count == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog expired after %0d cycles, tests did not complete", WATCHDOG_CYCLES);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule
